// File: filelist.f
+incdir+testbench
hw/isa_pkg.sv
hw/core_cfg_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/fetch_buffer.sv
hw/execute_stage.sv
hw/qar_core.sv
testbench/tb_qar_core.sv

// File: hw/core_cfg_pkg.sv
// ---------------------------------------
// Core configuration, 32-bit only
// Instruction fetch starts at RESET_PC
// ---------------------------------------
package core_cfg_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    localparam word_t RESET_PC = '0;

    // PC step per fetched word
    localparam word_t INSTR_BYTES = 4;

endpackage

// File: hw/execute_stage.sv
// ---------------------------------------
// Decode and execute stages with register file
// Never stalls; the head is taken whenever it is valid
// Writeback result is forwarded into decode in the same cycle
// Unsupported encodings retire with no register write
// A taken control transfer squashes the decode slot
// ---------------------------------------
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, core_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      head_valid,
    input  word_t     head_instr,
    input  word_t     head_pc,
    output logic      pop,

    output logic      redirect,
    output word_t     redirect_pc,

    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      rd_we,
    output reg_addr_t rd_addr,
    output word_t     rd_data
);

    // ---------------------------------------
    // Decode register
    // ---------------------------------------
    logic      id_valid;
    word_t     id_instr;
    word_t     id_pc;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     fwd_rs1;
    word_t     fwd_rs2;

    assign pop    = head_valid;
    assign id_rs1 = id_instr[19:15];
    assign id_rs2 = id_instr[24:20];

    reg_file reg_file_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rd_we),
        .waddr  (rd_addr),
        .wdata  (rd_data)
    );

    // rd_we is already low for x0
    assign fwd_rs1 = (rd_we && rd_addr == id_rs1) ? rd_data : rf_rdata1;
    assign fwd_rs2 = (rd_we && rd_addr == id_rs2) ? rd_data : rf_rdata2;

    // ---------------------------------------
    // Execute register
    // ---------------------------------------
    logic  ex_valid;
    word_t ex_instr;
    word_t ex_pc;
    word_t ex_rs1;
    word_t ex_rs2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            id_valid <= head_valid && !redirect;
            ex_valid <= id_valid && !redirect;   // Squash wrong-path decode
        end
    end

    always_ff @(posedge clk) begin
        id_instr <= head_instr;
        id_pc    <= head_pc;
        ex_instr <= id_instr;
        ex_pc    <= id_pc;
        ex_rs1   <= fwd_rs1;
        ex_rs2   <= fwd_rs2;
    end

    opcode_e             opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    word_t               imm_i;
    word_t               imm_b;
    word_t               imm_j;
    word_t               imm_u;
    word_t               pc_plus4;
    word_t               jalr_sum;

    assign opcode   = opcode_e'(ex_instr[6:0]);
    assign funct3   = ex_instr[14:12];
    assign funct7   = ex_instr[31:25];
    assign imm_i    = {{20{ex_instr[31]}}, ex_instr[31:20]};
    assign imm_b    = {{19{ex_instr[31]}}, ex_instr[31], ex_instr[7],
                       ex_instr[30:25], ex_instr[11:8], 1'b0};
    assign imm_j    = {{11{ex_instr[31]}}, ex_instr[31], ex_instr[19:12],
                       ex_instr[20], ex_instr[30:21], 1'b0};
    assign imm_u    = {ex_instr[31:12], 12'b0};
    assign pc_plus4 = ex_pc + INSTR_BYTES;
    assign jalr_sum = ex_rs1 + imm_i;

    // ---------------------------------------
    // ALU and control
    // ---------------------------------------
    alu_op_e alu_op;
    word_t   alu_b;
    word_t   alu_result;
    logic    wr_en;
    word_t   wr_data;
    logic    taken;
    word_t   target;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = ex_rs1 + alu_b;
            ALU_SUB: alu_result = ex_rs1 - alu_b;
            ALU_AND: alu_result = ex_rs1 & alu_b;
            ALU_OR:  alu_result = ex_rs1 | alu_b;
            ALU_XOR: alu_result = ex_rs1 ^ alu_b;
            ALU_SLL: alu_result = ex_rs1 << alu_b[4:0];
            ALU_SRL: alu_result = ex_rs1 >> alu_b[4:0];
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        alu_op  = ALU_ADD;
        alu_b   = ex_rs2;
        wr_en   = 1'b0;
        wr_data = alu_result;
        taken   = 1'b0;
        target  = ex_pc + imm_b;
        case (opcode)
            OPC_OP: begin
                wr_en = (funct7 == F7_BASE);   // Only SUB uses the alternate funct7
                case (funct3)
                    F3_ADD: begin
                        if (funct7 == F7_ALT) begin
                            alu_op = ALU_SUB;
                            wr_en  = 1'b1;
                        end
                    end
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SRL:  alu_op = ALU_SRL;   // No SRA
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: wr_en  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                alu_b = imm_i;
                wr_en = (funct3 == F3_ADD);   // ADDI only
            end
            OPC_LUI: begin
                wr_en   = 1'b1;
                wr_data = imm_u;
            end
            OPC_AUIPC: begin
                wr_en   = 1'b1;
                wr_data = ex_pc + imm_u;
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  taken = (ex_rs1 == ex_rs2);
                    F3_BNE:  taken = (ex_rs1 != ex_rs2);
                    F3_BLT:  taken = ($signed(ex_rs1) < $signed(ex_rs2));
                    F3_BGE:  taken = ($signed(ex_rs1) >= $signed(ex_rs2));
                    F3_BLTU: taken = (ex_rs1 < ex_rs2);
                    F3_BGEU: taken = (ex_rs1 >= ex_rs2);
                    default: taken = 1'b0;
                endcase
            end
            OPC_JAL: begin
                wr_en   = 1'b1;
                wr_data = pc_plus4;
                taken   = 1'b1;
                target  = ex_pc + imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    wr_en   = 1'b1;
                    wr_data = pc_plus4;
                    taken   = 1'b1;
                    target  = {jalr_sum[XLEN-1:1], 1'b0};
                end
            end
            default: ;
        endcase
    end

    assign retire_valid = ex_valid;
    assign retire_pc    = ex_pc;
    assign rd_addr      = ex_instr[11:7];
    assign rd_we        = ex_valid && wr_en && (rd_addr != '0);
    assign rd_data      = wr_data;
    assign redirect     = ex_valid && taken;
    assign redirect_pc  = target;

    // Redirect retires its own instruction and squashes both younger slots
    a_redirect_retire: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> retire_valid ##1 !retire_valid ##1 !retire_valid);

endmodule

// File: hw/fetch_buffer.sv
// ---------------------------------------
// In-order instruction buffer, FETCH_DEPTH entries
// Flush empties it in one cycle and beats a push
// Producer must not push when full
// ---------------------------------------
`timescale 1ns/1ps

module fetch_buffer import core_cfg_pkg::*; #(
    parameter int FETCH_DEPTH = 2,
    localparam int CNT_W = $clog2(FETCH_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             push,
    input  word_t            push_instr,
    input  word_t            push_pc,
    input  logic             pop,
    input  logic             flush,

    output logic             head_valid,
    output word_t            head_instr,
    output word_t            head_pc,
    output logic [CNT_W-1:0] count
);

    localparam int PTR_W = $clog2(FETCH_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FETCH_DEPTH - 1);

    word_t            instr_mem [FETCH_DEPTH];
    word_t            pc_mem    [FETCH_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    assign head_valid = (count != '0);
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            instr_mem[wr_ptr] <= push_instr;
            pc_mem[wr_ptr]    <= push_pc;
        end
    end

    // Fetch room check keeps pushes away from a full buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count < FETCH_DEPTH);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> head_valid);

endmodule

// File: hw/fetch_unit.sv
// ---------------------------------------
// Instruction fetch over valid/ready
// At most one request in flight; valid and address hold until ready
// A response that returns after a redirect is discarded
// New requests only while the fetch buffer has room for them
// ---------------------------------------
`timescale 1ns/1ps

module fetch_unit import core_cfg_pkg::*; #(
    parameter int FETCH_DEPTH = 2,
    localparam int CNT_W = $clog2(FETCH_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst_n,

    output logic             imem_valid,
    output word_t            imem_addr,
    input  logic             imem_ready,
    input  word_t            imem_rdata,

    input  logic [CNT_W-1:0] buf_count,
    input  logic             redirect,
    input  word_t            redirect_pc,

    output logic             push,
    output word_t            push_instr,
    output word_t            push_pc
);

    word_t pc_next;
    logic  drop;     // Outstanding response belongs to a squashed stream
    logic  transfer;
    logic  room;
    logic  issue;

    assign transfer = imem_valid && imem_ready;

    // Buffered words plus the one in flight must stay below depth
    assign room  = (int'(buf_count) + int'(imem_valid)) < FETCH_DEPTH;
    assign issue = (!imem_valid || transfer) && !redirect && room;

    assign push       = transfer && !drop && !redirect;
    assign push_instr = imem_rdata;
    assign push_pc    = imem_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_valid <= 1'b0;
            imem_addr  <= RESET_PC;
            pc_next    <= RESET_PC;
            drop       <= 1'b0;
        end else begin
            if (redirect)
                pc_next <= redirect_pc;
            else if (issue)
                pc_next <= pc_next + INSTR_BYTES;

            if (issue) begin
                imem_valid <= 1'b1;
                imem_addr  <= pc_next;
            end else if (transfer) begin
                imem_valid <= 1'b0;
            end

            if (redirect && imem_valid && !transfer)
                drop <= 1'b1;   // Wait out the old request
            else if (transfer)
                drop <= 1'b0;
        end
    end

    // Request must hold steady through back-pressure
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr));

endmodule

// File: hw/isa_pkg.sv
// ---------------------------------------
// RV32I encodings for the supported subset only
// OP-IMM decodes ADDI alone, other funct3 values are not executed
// ---------------------------------------
package isa_pkg;

    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // funct3 / funct7 values
    localparam logic [FUNCT3_W-1:0] F3_ADD = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_XOR = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR  = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND = 3'b111;

    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

endpackage

// File: hw/qar_core.sv
// ---------------------------------------
// Three-stage RV32I subset core, instruction side only
// External instruction memory over valid/ready
// Each retired instruction shows on the retire port
// FETCH_DEPTH must be 2 or more
// ---------------------------------------
`timescale 1ns/1ps

module qar_core import isa_pkg::*, core_cfg_pkg::*; #(
    parameter int FETCH_DEPTH = 2
) (
    input  logic      clk,
    input  logic      rst_n,

    output logic      imem_valid,
    output word_t     imem_addr,
    input  logic      imem_ready,
    input  word_t     imem_rdata,

    output logic      retire_valid,
    output word_t     retire_pc,
    output logic      rd_we,
    output reg_addr_t rd_addr,
    output word_t     rd_data
);

    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

    logic             push;
    word_t            push_instr;
    word_t            push_pc;
    logic             pop;
    logic             head_valid;
    word_t            head_instr;
    word_t            head_pc;
    logic [CNT_W-1:0] buf_count;
    logic             redirect;
    word_t            redirect_pc;

    fetch_unit #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) fetch_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_valid  (imem_valid),
        .imem_addr   (imem_addr),
        .imem_ready  (imem_ready),
        .imem_rdata  (imem_rdata),
        .buf_count   (buf_count),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .push        (push),
        .push_instr  (push_instr),
        .push_pc     (push_pc)
    );

    fetch_buffer #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) fetch_buffer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_instr (push_instr),
        .push_pc    (push_pc),
        .pop        (pop),
        .flush      (redirect),
        .head_valid (head_valid),
        .head_instr (head_instr),
        .head_pc    (head_pc),
        .count      (buf_count)
    );

    execute_stage execute_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .head_valid   (head_valid),
        .head_instr   (head_instr),
        .head_pc      (head_pc),
        .pop          (pop),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

endmodule

// File: hw/reg_file.sv
// ---------------------------------------
// 32 x 32 integer registers
// Combinational reads, write on the clock edge
// x0 has no storage and reads zero
// ---------------------------------------
`timescale 1ns/1ps

module reg_file import isa_pkg::*, core_cfg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [1:NUM_REGS-1];

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the qar_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert --top-module tb_qar_core \
        -Mdir obj_dir -o sim_qar -f filelist.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_qar > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: testbench/tb_program.svh
// ---------------------------------------
// Test program for the qar_core testbench
// Included inside tb_qar_core, uses its mem, loop_pc and MEM_WORDS
// Branch and jump offsets are byte offsets from the instruction
// ---------------------------------------
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

int prog_idx;   // Next word to write

function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
endfunction

function automatic word_t i_type(int imm, int rs1, logic [2:0] f3, int rd, opcode_e opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic word_t u_type(int imm, int rd, opcode_e opc);
    return {imm[19:0], rd[4:0], opc};
endfunction

function automatic word_t b_type(int off, int rs2, int rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic word_t j_type(int off, int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
endfunction

task automatic emit(input word_t instr);
    mem[prog_idx] = instr;
    prog_idx++;
endtask

task automatic load_program();
    word_t junk;
    junk = i_type(99, 0, F3_ADD, 13, OPC_OP_IMM);   // Must never retire
    for (int i = 0; i < MEM_WORDS; i++)
        mem[i] = {i[24:0], 7'h7f};   // Unsupported opcode, unique per word
    prog_idx = 0;
    emit(i_type(5, 0, F3_ADD, 1, OPC_OP_IMM));
    emit(i_type(-3, 1, F3_ADD, 2, OPC_OP_IMM));    // Forwarded x1
    emit(r_type(F7_BASE, 2, 1, F3_ADD, 3));
    emit(r_type(F7_ALT, 1, 2, F3_ADD, 4));         // x4 = -3
    emit(r_type(F7_BASE, 4, 3, F3_AND, 5));
    emit(r_type(F7_BASE, 4, 3, F3_OR, 6));
    emit(r_type(F7_BASE, 5, 6, F3_XOR, 7));
    emit(r_type(F7_BASE, 2, 1, F3_SLL, 8));
    emit(r_type(F7_BASE, 2, 4, F3_SRL, 9));
    emit(u_type('habcde, 10, OPC_LUI));
    emit(u_type('h12, 11, OPC_AUIPC));
    emit(i_type(7, 1, F3_ADD, 0, OPC_OP_IMM));     // Write to x0 is dropped
    emit(r_type(F7_BASE, 1, 0, F3_ADD, 12));       // x0 reads zero
    emit(r_type(F7_ALT, 2, 1, F3_XOR, 13));        // Unsupported, no write
    emit(b_type(8, 1, 1, F3_BEQ));                 // Taken
    emit(junk);
    emit(b_type(8, 1, 1, F3_BNE));                 // Not taken
    emit(b_type(8, 1, 4, F3_BLT));                 // -3 < 5, taken
    emit(junk);
    emit(b_type(8, 4, 1, F3_BGE));
    emit(junk);
    emit(b_type(8, 4, 1, F3_BLTU));                // Unsigned, taken
    emit(junk);
    emit(b_type(8, 4, 1, F3_BGEU));                // Not taken
    emit(b_type(8, 4, 1, F3_BLT));                 // Not taken
    emit(j_type(8, 14));
    emit(junk);
    emit(u_type(0, 15, OPC_AUIPC));
    emit(i_type(21, 15, 3'b000, 16, OPC_JALR));    // Odd target, bit 0 cleared
    emit(junk);
    emit(junk);
    emit(junk);
    loop_pc = word_t'(prog_idx * 4);
    emit(j_type(0, 0));                            // Jump to self
endtask

`endif

// File: testbench/tb_qar_core.sv
// ---------------------------------------
// Testbench for qar_core
// Instruction memory answers each request after 0 to 3 random cycles
// Shadow registers predict every retire in program order
// Ends once the closing JAL loop has retired three times
// ---------------------------------------
`timescale 1ns/1ps

module tb_qar_core import isa_pkg::*, core_cfg_pkg::*; ();

    localparam int MEM_WORDS      = 64;
    localparam int MEM_AW         = 6;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LOOP_RETIRES   = 3;

    logic      clk;
    logic      rst_n;
    logic      imem_valid;
    word_t     imem_addr;
    logic      imem_ready;
    word_t     imem_rdata;
    logic      retire_valid;
    word_t     retire_pc;
    logic      rd_we;
    reg_addr_t rd_addr;
    word_t     rd_data;

    word_t     mem [MEM_WORDS];
    word_t     loop_pc;
    word_t     shadow [NUM_REGS];
    word_t     expect_pc;   // PC of the next instruction to retire
    word_t     chk_pc;
    logic      chk_we;
    reg_addr_t chk_rd;
    word_t     chk_data;
    logic      seen_req;
    logic      busy;
    int        wait_cycles;
    int        loop_hits;
    int        retires;
    int        errors;

    `include "tb_program.svh"

    qar_core #(
        .FETCH_DEPTH (2)
    ) qar_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_valid   (imem_valid),
        .imem_addr    (imem_addr),
        .imem_ready   (imem_ready),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .rd_we        (rd_we),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I reference for the instruction at expect_pc
    task automatic predict_retire();
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_b;
        word_t      imm_j;
        word_t      res;
        word_t      nxt;
        logic       we;
        logic       cond;
        logic [2:0] f3;
        logic [6:0] f7;
        instr = mem[expect_pc[MEM_AW+1:2]];
        f3    = instr[14:12];
        f7    = instr[31:25];
        a     = shadow[instr[19:15]];
        b     = shadow[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        we    = 1'b0;
        cond  = 1'b0;
        res   = '0;
        nxt   = expect_pc + 4;
        case (instr[6:0])
            OPC_OP: begin
                we = 1'b1;
                case ({f7, f3})
                    {F7_BASE, F3_ADD}: res = a + b;
                    {F7_ALT,  F3_ADD}: res = a - b;
                    {F7_BASE, F3_AND}: res = a & b;
                    {F7_BASE, F3_OR}:  res = a | b;
                    {F7_BASE, F3_XOR}: res = a ^ b;
                    {F7_BASE, F3_SLL}: res = a << b[4:0];
                    {F7_BASE, F3_SRL}: res = a >> b[4:0];
                    default:           we = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                we  = (f3 == F3_ADD);
                res = a + imm_i;
            end
            OPC_LUI: begin
                we  = 1'b1;
                res = {instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                we  = 1'b1;
                res = expect_pc + {instr[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_BEQ:  cond = (a == b);
                    F3_BNE:  cond = (a != b);
                    F3_BLT:  cond = ($signed(a) < $signed(b));
                    F3_BGE:  cond = ($signed(a) >= $signed(b));
                    F3_BLTU: cond = (a < b);
                    F3_BGEU: cond = (a >= b);
                    default: cond = 1'b0;
                endcase
                if (cond)
                    nxt = expect_pc + imm_b;
            end
            OPC_JAL: begin
                we  = 1'b1;
                res = expect_pc + 4;
                nxt = expect_pc + imm_j;
            end
            OPC_JALR: begin
                if (f3 == 3'b000) begin
                    we  = 1'b1;
                    res = expect_pc + 4;
                    nxt = (a + imm_i) & ~word_t'(1);
                end
            end
            default: ;
        endcase
        chk_pc   = expect_pc;
        chk_we   = we && (instr[11:7] != 5'd0);
        chk_rd   = instr[11:7];
        chk_data = res;
        if (chk_we)
            shadow[chk_rd] = res;
        if (expect_pc == loop_pc)
            loop_hits++;
        retires++;
        expect_pc = nxt;
    endtask

    // Memory responder, one request at a time
    always @(negedge clk) begin
        if (imem_ready) begin
            imem_ready = 1'b0;   // Transfer on the last rising edge
            busy       = 1'b0;
            seen_req   = 1'b1;
        end
        if (imem_valid && !busy) begin
            busy        = 1'b1;
            wait_cycles = int'($urandom % 4);
        end
        if (busy) begin
            if (wait_cycles == 0) begin
                imem_ready = 1'b1;
                imem_rdata = mem[imem_addr[MEM_AW+1:2]];
            end else begin
                wait_cycles--;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && retire_valid)
            predict_retire();
    end

    // ---------------------------------------
    // Checks
    // ---------------------------------------
    a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        imem_valid && !seen_req |-> imem_addr == RESET_PC)
        else begin
            errors++;
            $display("FAIL %0t: first fetch address %h", $time, $sampled(imem_addr));
        end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr))
        else begin
            errors++;
            $display("FAIL %0t: fetch request changed before ready", $time);
        end

    a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_pc == chk_pc)
        else begin
            errors++;
            $display("FAIL %0t: retire pc %h, expected %h", $time,
                     $sampled(retire_pc), $sampled(chk_pc));
        end

    a_retire_we: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> rd_we == chk_we)
        else begin
            errors++;
            $display("FAIL %0t: rd_we %b at pc %h, expected %b", $time,
                     $sampled(rd_we), $sampled(chk_pc), $sampled(chk_we));
        end

    a_retire_data: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && chk_we |-> rd_addr == chk_rd && rd_data == chk_data)
        else begin
            errors++;
            $display("FAIL %0t: x%0d = %h at pc %h, expected x%0d = %h", $time,
                     $sampled(rd_addr), $sampled(rd_data), $sampled(chk_pc),
                     $sampled(chk_rd), $sampled(chk_data));
        end

    a_no_stray_write: assert property (@(posedge clk) disable iff (!rst_n)
        !retire_valid |-> !rd_we)
        else begin
            errors++;
            $display("FAIL %0t: register write without retire", $time);
        end

    initial begin
        int cycles;
        void'($urandom(32'h85309e14));
        rst_n       = 1'b0;
        imem_ready  = 1'b0;
        imem_rdata  = '0;
        busy        = 1'b0;
        wait_cycles = 0;
        seen_req    = 1'b0;
        loop_hits   = 0;
        retires     = 0;
        errors      = 0;
        expect_pc   = RESET_PC;
        chk_pc      = '0;
        chk_we      = 1'b0;
        chk_rd      = '0;
        chk_data    = '0;
        for (int i = 0; i < NUM_REGS; i++)
            shadow[i] = '0;
        load_program();

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        cycles = 0;
        while (loop_hits < LOOP_RETIRES && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (loop_hits < LOOP_RETIRES) begin
            errors++;
            $display("Timeout: closing loop retired %0d times in %0d cycles", loop_hits, cycles);
        end
        @(negedge clk);   // Let the last retire check complete

        $display("Checks done: %0d retires, %0d errors", retires, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
